//--- sim.f
fma16_pkg.sv
fma16_unpack.sv
fma16_product.sv
fma16_align_and_sum.sv
fma16_normalize.sv
fma16_axil_regs.sv
fma16_top.sv
fma16_asserts.sv
tb_fma16.sv

//--- tb_fma16.sv
//////////////////////////////////////////////////
// fma16 testbench
// drives the AXI4-Lite slave through a table of fma cases
// plus register readback and bad access checks
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fma16
    import fma16_pkg::*;
();

    localparam int NUM_ROWS       = 15;
    localparam int MAX_POLLS      = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

    logic        clk;
    logic        rst;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    integer      seed;
    int          cycles;
    int          value_errors;
    int          poll_errors;
    logic [66:0] rows [NUM_ROWS];  // x, y, z, result word, {zero, overflow, inexact}
    logic [15:0] op_x;
    logic [15:0] op_y;
    logic [15:0] op_z;
    logic [15:0] exp_res;
    logic [2:0]  exp_flags;
    logic [31:0] word;
    logic [31:0] last_result;
    logic [15:0] last_val [3];
    logic [4:0]  op_addr [3];
    logic        seen;
    fp16_t       got;

    fma16_top UUT (.*);

    always #4 clk = ~clk;

    // run limit from the table length plus room for the register tests
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence never finished", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_word(input logic [31:0] got_w, input logic [31:0] exp_w,
                              input string what);
        assert (got_w === exp_w) else begin
            value_errors++;
            $display("FAILED %0t: %s read %h, expected %h", $time, what, got_w, exp_w);
        end
    endtask

    // moves on to the drive point 1 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int hold;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        #1;                                         // ready lines follow the new valids
        while (!(awready && wready))
            next_cycle();
        next_cycle();                               // accepted on this edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        hold    = $unsigned($random(seed)) % 4;     // bready back-pressure
        repeat (hold)
            next_cycle();
        while (!bvalid)
            next_cycle();
        bready = 1'b1;
        assert (bresp === exp_resp) else begin
            value_errors++;
            $display("FAILED %0t: write to %h answered %0d, expected %0d",
                     $time, addr, bresp, exp_resp);
        end
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        int hold;
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready)
            next_cycle();
        next_cycle();
        arvalid = 1'b0;
        hold    = $unsigned($random(seed)) % 4;     // rready back-pressure
        repeat (hold)
            next_cycle();
        while (!rvalid)
            next_cycle();
        rready = 1'b1;
        data   = rdata;
        assert (rresp === exp_resp) else begin
            value_errors++;
            $display("FAILED %0t: read of %h answered %0d, expected %0d",
                     $time, addr, rresp, exp_resp);
        end
        next_cycle();
        rready = 1'b0;
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed = 32'hb392_fb34;
        cycles = 0;
        value_errors = 0;
        poll_errors = 0;
        op_addr[0] = ADDR_X;
        op_addr[1] = ADDR_Y;
        op_addr[2] = ADDR_Z;

        // worked out by hand with one truncation at the end
        rows[0]  = {16'h3E00, 16'h4000, 16'h3400, 16'h4280, 3'b000}; // 1.5*2+0.25 = 3.25
        rows[1]  = {16'h0000, 16'h4200, 16'hC500, 16'hC500, 3'b000}; // zero factor passes z
        rows[2]  = {16'h4200, 16'h4400, 16'h0000, 16'h4A00, 3'b000}; // 3*4 with z zero
        rows[3]  = {16'hC200, 16'h4000, 16'h3C00, 16'hC500, 3'b000}; // -6+1 where the product wins
        rows[4]  = {16'h3E00, 16'h4000, 16'hC200, 16'h0000, 3'b100}; // 3-3 cancels
        rows[5]  = {16'hC000, 16'h3A00, 16'h3E00, 16'h0000, 3'b100}; // -1.5+1.5 is +0
        rows[6]  = {16'h3C00, 16'h3800, 16'hC400, 16'hC300, 3'b000}; // 0.5-4 takes the sign of z
        rows[7]  = {16'h3E00, 16'h4000, 16'h3C00, 16'h4400, 3'b000}; // carry to 4.0
        rows[8]  = {16'h3C01, 16'h3C01, 16'h0000, 16'h3C02, 3'b001}; // 2^-20 dropped
        rows[9]  = {16'h3C00, 16'h3C00, 16'h0C00, 16'h3C00, 3'b001}; // 1+2^-12 truncates
        rows[10] = {16'h5800, 16'h5800, 16'h8400, 16'h73FF, 3'b001}; // 2^14-2^-14
        rows[11] = {16'h5C00, 16'h5C00, 16'h0000, 16'h7C00, 3'b011}; // 65536 overflows
        rows[12] = {16'hDC00, 16'h5C00, 16'h0000, 16'hFC00, 3'b011}; // negative overflow
        rows[13] = {16'h9400, 16'h1400, 16'h0000, 16'h8000, 3'b101}; // -2^-20 flushes
        rows[14] = {16'h0001, 16'h3C00, 16'h3C00, 16'h3C00, 3'b000}; // subnormal x is zero

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        ////////////////////////////////////////////////// reset state
        for (int i = 0; i < 3; i++) begin
            read_reg(op_addr[i], RESP_OKAY, word);
            check_word(word, 32'h0, "operand after reset");
        end
        read_reg(ADDR_RESULT, RESP_OKAY, word);
        check_word(word, 32'h0, "RESULT after reset");  // valid bit low too

        ////////////////////////////////////////////////// arithmetic table
        for (int row = 0; row < NUM_ROWS; row++) begin
            {op_x, op_y, op_z, exp_res, exp_flags} = rows[row];
            write_reg(ADDR_X, {16'h0, op_x}, RESP_OKAY);
            write_reg(ADDR_Y, {16'h0, op_y}, RESP_OKAY);
            write_reg(ADDR_Z, {16'h0, op_z}, RESP_OKAY);
            write_reg(ADDR_CTRL, 32'h1, RESP_OKAY);
            seen = 1'b0;
            for (int p = 0; p < MAX_POLLS && !seen; p++) begin
                read_reg(ADDR_RESULT, RESP_OKAY, word);
                seen = word[16];
            end
            assert (seen) else begin
                poll_errors++;
                $display("case %0d never showed the valid bit in RESULT", row);
            end
            assert (!seen || word === {12'h0, exp_flags, 1'b1, exp_res}) else begin
                value_errors++;
                got.bits = word[15:0];
                $display("FAILED %0t: case %0d gave %h (s %b e %0d m %h) flags %b, %s",
                         $time, row, got.bits, got.f.sign, got.f.exp, got.f.man,
                         word[19:17], $sformatf("expected %h flags %b", exp_res, exp_flags));
            end
            last_result = word;
        end

        ////////////////////////////////////////////////// readback
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 3; i++) begin
                word = $random(seed);               // upper half must not stick
                last_val[i] = word[15:0];
                write_reg(op_addr[i], word, RESP_OKAY);
                read_reg(op_addr[i], RESP_OKAY, word);
                check_word(word, {16'h0, last_val[i]}, "operand readback");
            end
        end

        ////////////////////////////////////////////////// bad access
        write_reg(ADDR_RESULT, 32'hFFFF_FFFF, RESP_SLVERR);
        write_reg(5'h14, 32'h0000_ABCD, RESP_SLVERR);
        read_reg(5'h1C, RESP_SLVERR, word);
        check_word(word, 32'h0, "unmapped read");
        for (int i = 0; i < 3; i++) begin
            read_reg(op_addr[i], RESP_OKAY, word);
            check_word(word, {16'h0, last_val[i]}, "operand after bad access");
        end
        read_reg(ADDR_RESULT, RESP_OKAY, word);
        check_word(word, last_result, "RESULT after bad access");

        $display("errors: %0d wrong values, %0d missing results", value_errors, poll_errors);
        if (value_errors + poll_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- fma16_asserts.sv
//////////////////////////////////////////////////
// fma16 bus and pipeline assertions
// AXI4-Lite channel rules and start to done latency
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_asserts
    import fma16_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        awvalid,
    input logic        wvalid,
    input logic        awready,
    input logic        wready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        start,
    input logic        done
);

    // a write response stays up and unchanged until the master takes it
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read data dropped or changed before rready");

    // both readies come together on an accepted write and the response follows next cycle
    aw_only_with_both: assert property (@(posedge clk) disable iff (rst)
        awready |-> (awvalid && wvalid && wready) ##1 bvalid)
        else $error("write accepted without both valids and readies or no response followed");

    // the pipeline never stalls so done trails start by a fixed count
    start_to_done: assert property (@(posedge clk) disable iff (rst)
        start |-> ##PIPE_LATENCY done)
        else $error("done did not follow start after the pipeline latency");

endmodule

bind fma16_axil_regs fma16_asserts u_asserts (.*);

//--- fma16_top.sv
//////////////////////////////////////////////////
// fma16 top level
// AXI4-Lite register block in front of the three stage fma pipeline
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_top
    import fma16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    // operands and start from the registers
    logic [15:0]                 x;
    logic [15:0]                 y;
    logic [15:0]                 z;
    logic                        start;

    // product stage outputs
    logic                        in_valid;
    logic                        ps;
    logic signed [EXP_INT_W-1:0] pe;
    logic [PROD_W-1:0]           pm;
    logic                        zs;
    logic [EXP_W-1:0]            ze;
    logic [MAN_W:0]              zm;
    logic                        p_zero;
    logic                        z_zero;

    // sum stage outputs
    logic                        sum_valid;
    logic [SUM_W-1:0]            sm;
    logic                        sum_sign;
    logic signed [EXP_INT_W-1:0] sum_exp;
    logic                        sticky;
    logic                        sum_zero;

    // result stage outputs back into the registers
    logic                        done;
    fp16_t                       result;
    logic                        inexact;
    logic                        overflow;
    logic                        zero;

    fma16_axil_regs u_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .result, .inexact, .overflow, .zero, .done,
        .x, .y, .z, .start
    );

    fma16_product u_product (
        .clk, .rst, .start, .x, .y, .z,
        .in_valid, .ps, .pe, .pm, .zs, .ze, .zm, .p_zero, .z_zero
    );

    fma16_align_and_sum u_align_and_sum (
        .clk, .rst, .in_valid, .ps, .pe, .pm, .zs, .ze, .zm, .p_zero, .z_zero,
        .sum_valid, .sm, .sum_sign, .sum_exp, .sticky, .sum_zero
    );

    fma16_normalize u_normalize (
        .clk, .rst, .sum_valid, .sm, .sum_sign, .sum_exp, .sticky, .sum_zero,
        .done, .result, .inexact, .overflow, .zero
    );

endmodule

//--- fma16_axil_regs.sv
//////////////////////////////////////////////////
// fma16 register block
// AXI4-Lite slave with the operand, control and result registers
// issues the start pulse and captures the pipeline result on done
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_axil_regs
    import fma16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,      // byte strobes are not supported, every write is full word
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [15:0] result,     // packed result word from the result stage
    input  logic        inexact,
    input  logic        overflow,
    input  logic        zero,
    input  logic        done,
    output logic [15:0] x,
    output logic [15:0] y,
    output logic [15:0] z,
    output logic        start
);

    logic        wr_en;             // write accepted this cycle
    logic        rd_en;             // read accepted this cycle
    logic        wr_ok;             // write address is a writable register
    logic        rd_ok;             // read address is mapped
    logic [31:0] rd_mux;
    logic [15:0] res_word;
    logic        res_valid;
    logic        res_inexact;
    logic        res_overflow;
    logic        res_zero;
    logic [1:0]  in_flight;         // operations between start and done

    // address and data are taken together, and only with no response outstanding
    assign wr_en   = awvalid & wvalid & ~bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;
    assign rd_en   = arvalid & ~rvalid;
    assign arready = rd_en;

    // RESULT is read only so only the four input registers take writes
    assign wr_ok = awaddr inside {ADDR_X, ADDR_Y, ADDR_Z, ADDR_CTRL};

    always_comb begin
        rd_ok = 1'b1;
        case (araddr)
            ADDR_X:      rd_mux = {16'h0000, x};
            ADDR_Y:      rd_mux = {16'h0000, y};
            ADDR_Z:      rd_mux = {16'h0000, z};
            ADDR_CTRL:   rd_mux = '0;   // start bit is self clearing
            ADDR_RESULT: rd_mux = {12'h000, res_zero, res_overflow, res_inexact, res_valid,
                                   res_word};
            default: begin
                rd_mux = '0;
                rd_ok  = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // write channel and operand registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            x      <= '0;
            y      <= '0;
            z      <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;              // single cycle pulse
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                case (awaddr)
                    ADDR_X:    x <= wdata[15:0];
                    ADDR_Y:    y <= wdata[15:0];
                    ADDR_Z:    z <= wdata[15:0];
                    ADDR_CTRL: start <= wdata[0];
                    default: ;          // unmapped or RESULT leaves everything alone
                endcase
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // result capture
    //////////////////////////////////////////////////
    // valid comes back only with the done of the newest start so an older
    // operation finishing late never shows up as the answer
    always_ff @(posedge clk) begin
        if (rst) begin
            res_word     <= '0;
            res_valid    <= 1'b0;
            res_inexact  <= 1'b0;
            res_overflow <= 1'b0;
            res_zero     <= 1'b0;
            in_flight    <= '0;
        end else begin
            case ({start, done})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: ;              // both or neither keeps the count
            endcase
            if (done) begin
                res_word     <= result;
                res_inexact  <= inexact;
                res_overflow <= overflow;
                res_zero     <= zero;
                if (in_flight == 2'd1 && !start)
                    res_valid <= 1'b1;
            end
            if (start)
                res_valid <= 1'b0;      // a new operation hides the old answer
        end
    end

    //////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else if (rd_en) begin
            rvalid <= 1'b1;
            rdata  <= rd_mux;           // held stable until rready
            rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

//--- fma16_normalize.sv
//////////////////////////////////////////////////
// fma16 result stage
// normalizes the sum, truncates to binary16 and sets the flags
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_normalize
    import fma16_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sum_valid,
    input  logic [SUM_W-1:0]            sm,
    input  logic                        sum_sign,
    input  logic signed [EXP_INT_W-1:0] sum_exp,
    input  logic                        sticky,
    input  logic                        sum_zero,
    output logic                        done,
    output fp16_t                       result,
    output logic                        inexact,
    output logic                        overflow,
    output logic                        zero
);

    logic [5:0]                  lead;     // position of the leading one in sm
    logic signed [EXP_INT_W-1:0] exp_n;    // biased exponent after normalizing
    logic [SUM_W-1:0]            norm;     // leading one moved to the msb
    logic                        lost;
    fp16_t                       res_c;
    logic                        inx_c;
    logic                        ovf_c;
    logic                        zero_c;

    // the highest set bit wins since the loop runs upward
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (sm[i])
                lead = 6'(i);
        end
    end

    assign norm  = sm << (SUM_W - 1 - lead);
    assign exp_n = sum_exp + EXP_INT_W'(lead) - EXP_INT_W'(BIN_POINT);

    // everything under the ten kept mantissa bits is dropped by round toward zero
    assign lost = sticky | (|norm[SUM_W-MAN_W-2:0]);

    //////////////////////////////////////////////////
    // range check and packing
    //////////////////////////////////////////////////
    always_comb begin
        res_c.bits  = '0;
        res_c.f.sign = sum_sign;
        inx_c       = lost;
        ovf_c       = 1'b0;
        zero_c      = 1'b0;
        if (sum_zero) begin
            zero_c = 1'b1;                  // signed zero straight through
        end else if (exp_n > 2 * EXP_BIAS) begin
            res_c.f.exp = '1;               // infinity, mantissa stays zero
            ovf_c       = 1'b1;
            inx_c       = 1'b1;
        end else if (exp_n < 1) begin
            zero_c = 1'b1;                  // too small for a normal, flushed
            inx_c  = 1'b1;
        end else begin
            res_c.f.exp = exp_n[EXP_W-1:0];
            res_c.f.man = norm[SUM_W-2 -: MAN_W];   // hidden bit dropped
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else
            done <= sum_valid;
    end

    always_ff @(posedge clk) begin
        result   <= res_c;
        inexact  <= inx_c;
        overflow <= ovf_c;
        zero     <= zero_c;
    end

endmodule

//--- fma16_align_and_sum.sv
//////////////////////////////////////////////////
// fma16 align and sum stage
// lines up z against the product and adds or subtracts the two
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_align_and_sum
    import fma16_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic                        ps,
    input  logic signed [EXP_INT_W-1:0] pe,
    input  logic [PROD_W-1:0]           pm,
    input  logic                        zs,
    input  logic [EXP_W-1:0]            ze,
    input  logic [MAN_W:0]              zm,
    input  logic                        p_zero,
    input  logic                        z_zero,
    output logic                        sum_valid,
    output logic [SUM_W-1:0]            sm,        // magnitude with 1.0 on BIN_POINT
    output logic                        sum_sign,
    output logic signed [EXP_INT_W-1:0] sum_exp,   // biased exponent of weight BIN_POINT
    output logic                        sticky,    // ones lost below bit 0
    output logic                        sum_zero
);

    logic signed [EXP_INT_W-1:0] ze_i;
    logic signed [EXP_INT_W-1:0] exp_diff;
    logic [EXP_INT_W-1:0]        shamt;
    logic                        big_is_p;
    logic                        eff_sub;
    logic                        big_sign;
    logic                        small_sign;
    logic                        lost;
    logic [SUM_W-1:0]            p_base;
    logic [SUM_W-1:0]            z_base;
    logic [SUM_W-1:0]            big_vec;
    logic [SUM_W-1:0]            small_base;
    logic [SUM_W-1:0]            small_sh;
    logic [SUM_W-1:0]            small_al;
    logic [SUM_W-1:0]            sum_c;
    logic                        sign_c;

    assign ze_i     = EXP_INT_W'(ze);
    assign exp_diff = pe - ze_i;

    // both mantissas placed so their binary points meet on BIN_POINT
    assign p_base = SUM_W'(pm) << GUARD_BITS;
    assign z_base = SUM_W'(zm) << (BIN_POINT - MAN_W);

    // the operand with the larger exponent stays put and the other moves right
    // z moves when the product leads, otherwise the product moves under z
    assign big_is_p   = z_zero | (!p_zero && exp_diff >= 0);
    assign shamt      = big_is_p ? exp_diff : -exp_diff;
    assign big_vec    = big_is_p ? p_base : z_base;
    assign small_base = big_is_p ? z_base : p_base;
    assign big_sign   = big_is_p ? ps : zs;
    assign small_sign = big_is_p ? zs : ps;
    assign eff_sub    = ps ^ zs;

    assign small_sh = small_base >> shamt;
    assign lost     = (small_sh << shamt) != small_base;   // shifted past bit 0

    // on a subtract the lost bits make the true difference a little smaller
    // so a one is folded into the lsb and truncation then lands on the right side
    assign small_al = small_sh | SUM_W'(lost & eff_sub);

    //////////////////////////////////////////////////
    // add or subtract the magnitudes
    //////////////////////////////////////////////////
    always_comb begin
        if (!eff_sub) begin
            sum_c  = big_vec + small_al;
            sign_c = big_sign;
        end else if (big_vec >= small_al) begin
            sum_c  = big_vec - small_al;
            sign_c = big_sign;
        end else begin
            sum_c  = small_al - big_vec;   // product outgrew z at close exponents
            sign_c = small_sign;
        end
        // exact cancellation gives +0, two zeros of one sign keep it
        if (sum_c == '0)
            sign_c = ps & zs;
    end

    always_ff @(posedge clk) begin
        if (rst)
            sum_valid <= 1'b0;
        else
            sum_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        sm       <= sum_c;
        sum_sign <= sign_c;
        sum_exp  <= big_is_p ? pe : ze_i;
        sticky   <= lost;
        sum_zero <= (sum_c == '0);
    end

endmodule

//--- fma16_product.sv
//////////////////////////////////////////////////
// fma16 product stage
// multiplies x by y and carries the z fields along
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_product
    import fma16_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  fp16_t                       x,
    input  fp16_t                       y,
    input  fp16_t                       z,
    output logic                        in_valid,
    output logic                        ps,
    output logic signed [EXP_INT_W-1:0] pe,      // biased product exponent, may go negative
    output logic [PROD_W-1:0]           pm,      // 2.20 fixed point product mantissa
    output logic                        zs,
    output logic [EXP_W-1:0]            ze,
    output logic [MAN_W:0]              zm,
    output logic                        p_zero,
    output logic                        z_zero
);

    logic             xs;
    logic             ys;
    logic             zs_d;
    logic [EXP_W-1:0] xe;
    logic [EXP_W-1:0] ye;
    logic [EXP_W-1:0] ze_d;
    logic [MAN_W:0]   xm;
    logic [MAN_W:0]   ym;
    logic [MAN_W:0]   zm_d;
    logic             x_zero;
    logic             y_zero;
    logic             z_zero_d;

    fma16_unpack u_unpack (
        .x, .y, .z,
        .xs, .ys, .zs(zs_d),
        .xe, .ye, .ze(ze_d),
        .xm, .ym, .zm(zm_d),
        .x_zero, .y_zero, .z_zero(z_zero_d)
    );

    always_ff @(posedge clk) begin
        if (rst)
            in_valid <= 1'b0;
        else
            in_valid <= start;
    end

    // datapath registers load every cycle, the valid bit says which ones count
    always_ff @(posedge clk) begin
        ps     <= xs ^ ys;
        pe     <= EXP_INT_W'(xe) + EXP_INT_W'(ye) - EXP_INT_W'(EXP_BIAS);
        pm     <= xm * ym;              // flushed factor already has a zero mantissa
        p_zero <= x_zero | y_zero;
        zs     <= zs_d;
        ze     <= ze_d;
        zm     <= zm_d;
        z_zero <= z_zero_d;
    end

endmodule

//--- fma16_unpack.sv
//////////////////////////////////////////////////
// fma16 decode
// splits x, y and z into sign, exponent and mantissa
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fma16_unpack
    import fma16_pkg::*;
(
    input  fp16_t            x,
    input  fp16_t            y,
    input  fp16_t            z,
    output logic             xs,
    output logic             ys,
    output logic             zs,
    output logic [EXP_W-1:0] xe,
    output logic [EXP_W-1:0] ye,
    output logic [EXP_W-1:0] ze,
    output logic [MAN_W:0]   xm,     // mantissa with the hidden bit on top
    output logic [MAN_W:0]   ym,
    output logic [MAN_W:0]   zm,
    output logic             x_zero,
    output logic             y_zero,
    output logic             z_zero
);

    // exponent zero covers true zero and subnormals, both flush to zero
    assign x_zero = (x.f.exp == '0);
    assign y_zero = (y.f.exp == '0);
    assign z_zero = (z.f.exp == '0);

    assign xs = x.f.sign;
    assign ys = y.f.sign;
    assign zs = z.f.sign;

    assign xe = x.f.exp;
    assign ye = y.f.exp;
    assign ze = z.f.exp;

    // a flushed operand gives an all zero mantissa so its product or sum vanishes
    assign xm = x_zero ? '0 : {1'b1, x.f.man};
    assign ym = y_zero ? '0 : {1'b1, y.f.man};
    assign zm = z_zero ? '0 : {1'b1, z.f.man};

endmodule

//--- fma16_pkg.sv
//////////////////////////////////////////////////
// fma16 shared definitions
// binary16 word view, datapath widths, register map and bus codes
//////////////////////////////////////////////////
package fma16_pkg;

    // binary16 field widths and exponent bias
    localparam int EXP_W    = 5;
    localparam int MAN_W    = 10;
    localparam int EXP_BIAS = 15;

    // datapath widths
    localparam int PROD_W     = 22;    // product of two 11-bit mantissas
    localparam int SUM_W      = 36;    // alignment and sum vector with carry room on top
    localparam int GUARD_BITS = 12;    // zero bits kept below the product lsb
    localparam int EXP_INT_W  = 8;     // signed exponent width inside the pipeline
    localparam int BIN_POINT  = GUARD_BITS + PROD_W - 2;  // weight 1.0 sits on this bit of the sum

    // register offsets on the slave
    localparam logic [4:0] ADDR_X      = 5'h00;
    localparam logic [4:0] ADDR_Y      = 5'h04;
    localparam logic [4:0] ADDR_Z      = 5'h08;
    localparam logic [4:0] ADDR_CTRL   = 5'h0C;
    localparam logic [4:0] ADDR_RESULT = 5'h10;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam int PIPE_LATENCY = 3;   // cycles from start to done

    // a binary16 word seen either as raw bits or as its ieee fields
    typedef union packed {
        logic [15:0] bits;
        struct packed {
            logic             sign;
            logic [EXP_W-1:0] exp;
            logic [MAN_W-1:0] man;
        } f;
    } fp16_t;

endpackage
